// File: Bender.yml
package:
  name: axis_array_pkt_chk

sources:
  - files:
      - design/pkt_chk_pkg.sv
      - design/pkt_assembler.sv
      - design/pkt_matcher.sv
      - design/axis_pkt_chk.sv
      - design/axis_array_pkt_chk.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_axis_array_pkt_chk.sv

// File: design/axis_array_pkt_chk.sv
// multi-port packet checker top
// one checker per stream port

`timescale 1ns/1ps

module axis_array_pkt_chk (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    // streams, one per port
    input  logic [pkt_chk_pkg::NUM_PORTS-1:0]                           s_valid,
    input  pkt_chk_pkg::axis_beat_t [pkt_chk_pkg::NUM_PORTS-1:0]        s_beat,
    output logic [pkt_chk_pkg::NUM_PORTS-1:0]                           s_ready,
    // shared table load port
    input  logic                                                        exp_wr,
    input  logic [$clog2(pkt_chk_pkg::NUM_PORTS)-1:0]                   exp_port,
    input  logic [pkt_chk_pkg::SLOT_W-1:0]                              exp_slot,
    input  pkt_chk_pkg::pkt_t                                           exp_pkt,
    // per port results
    output pkt_chk_pkg::chk_result_t [pkt_chk_pkg::NUM_PORTS-1:0]       result,
    output logic [pkt_chk_pkg::NUM_PORTS-1:0][pkt_chk_pkg::CNT_W-1:0]   match_cnt,
    output logic [pkt_chk_pkg::NUM_PORTS-1:0][pkt_chk_pkg::CNT_W-1:0]   miss_cnt,
    output logic [pkt_chk_pkg::NUM_PORTS-1:0]                           done
);

    // per port write strobe
    logic [pkt_chk_pkg::NUM_PORTS-1:0] port_wr;

    // sizes must tile into whole beats
    if (pkt_chk_pkg::MTU_BYTES % pkt_chk_pkg::DATA_BYTES != 0) begin : g_bad_mtu
        $error("MTU_BYTES is not a multiple of DATA_BYTES");
    end
    if (pkt_chk_pkg::NUM_PORTS < 2) begin : g_bad_ports
        $error("need at least two ports");
    end

    // exp_port one-hot decode
    always_comb begin
        for (int p = 0; p < pkt_chk_pkg::NUM_PORTS; p++) begin
            port_wr[p] = exp_wr && (exp_port == p);
        end
    end

    for (genvar p = 0; p < pkt_chk_pkg::NUM_PORTS; p++) begin : g_port
        axis_pkt_chk u_axis_pkt_chk (
            .clk       (clk),
            .rst_n     (rst_n),
            .s_valid   (s_valid[p]),
            .s_beat    (s_beat[p]),
            .s_ready   (s_ready[p]),
            .exp_wr    (port_wr[p]),
            .exp_slot  (exp_slot),
            .exp_pkt   (exp_pkt),
            .result    (result[p]),
            .match_cnt (match_cnt[p]),
            .miss_cnt  (miss_cnt[p]),
            .done      (done[p])
        );
    end

endmodule

// File: design/axis_pkt_chk.sv
// single port packet checker
// assembler feeding the slot matcher

`timescale 1ns/1ps

module axis_pkt_chk (
    input  logic                           clk,
    input  logic                           rst_n,
    // stream in
    input  logic                           s_valid,
    input  pkt_chk_pkg::axis_beat_t        s_beat,
    output logic                           s_ready,
    // expected table load
    input  logic                           exp_wr,
    input  logic [pkt_chk_pkg::SLOT_W-1:0] exp_slot,
    input  pkt_chk_pkg::pkt_t              exp_pkt,
    // results
    output pkt_chk_pkg::chk_result_t       result,
    output logic [pkt_chk_pkg::CNT_W-1:0]  match_cnt,
    output logic [pkt_chk_pkg::CNT_W-1:0]  miss_cnt,
    output logic                           done
);

    // assembler to matcher handoff
    logic              rx_valid;
    pkt_chk_pkg::pkt_t rx_pkt;
    logic              rx_ovf;
    // compare in progress, stalls tready
    logic              busy;

    pkt_assembler u_pkt_assembler (
        .clk      (clk),
        .rst_n    (rst_n),
        .s_valid  (s_valid),
        .s_beat   (s_beat),
        .s_ready  (s_ready),
        .busy     (busy),
        .rx_valid (rx_valid),
        .rx_pkt   (rx_pkt),
        .rx_ovf   (rx_ovf)
    );

    pkt_matcher u_pkt_matcher (
        .clk       (clk),
        .rst_n     (rst_n),
        .exp_wr    (exp_wr),
        .exp_slot  (exp_slot),
        .exp_pkt   (exp_pkt),
        .rx_valid  (rx_valid),
        .rx_pkt    (rx_pkt),
        .rx_ovf    (rx_ovf),
        .busy      (busy),
        .result    (result),
        .match_cnt (match_cnt),
        .miss_cnt  (miss_cnt),
        .done      (done)
    );

    // tready comes back the cycle after a result, not sooner
    a_ready_after: assert property (@(posedge clk) disable iff (!rst_n)
        (result.match || result.miss) |-> !s_ready ##1 s_ready);

endmodule

// File: design/pkt_assembler.sv
// stream beat to packet assembler
// one packet vector per tlast

`timescale 1ns/1ps

module pkt_assembler (
    input  logic                    clk,
    input  logic                    rst_n,
    // stream side
    input  logic                    s_valid,
    input  pkt_chk_pkg::axis_beat_t s_beat,
    output logic                    s_ready,
    // matcher side
    input  logic                    busy,
    output logic                    rx_valid,
    output pkt_chk_pkg::pkt_t       rx_pkt,
    output logic                    rx_ovf
);

    // beat pointer counts 0..MTU_BEATS, top value means packet is full
    logic [$clog2(pkt_chk_pkg::MTU_BEATS):0] beat_ptr;
    // bytes of full beats so far
    logic [pkt_chk_pkg::BLEN_W-1:0]          byte_cnt;
    // sticky overflow for the packet in flight
    logic                                    ovf;
    logic                                    beat_acc;
    logic                                    beat_over;
    // valid bytes in the current beat
    logic [pkt_chk_pkg::BLEN_W-1:0]          last_bytes;

    // hold the source off while a packet is handed over or compared
    assign s_ready   = !busy && !rx_valid;
    assign beat_acc  = s_valid && s_ready;
    assign beat_over = (beat_ptr == pkt_chk_pkg::MTU_BEATS);

    // ones in tkeep
    always_comb begin
        last_bytes = '0;
        for (int i = 0; i < pkt_chk_pkg::DATA_BYTES; i++) begin
            if (s_beat.tkeep[i]) begin
                last_bytes = last_bytes + 1'b1;
            end
        end
    end

    // pointer, byte count, overflow and handoff strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_ptr <= '0;
            byte_cnt <= '0;
            ovf      <= 1'b0;
            rx_valid <= 1'b0;
            rx_ovf   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (beat_acc) begin
                if (s_beat.tlast) begin
                    // present packet next cycle, restart for the next one
                    rx_valid <= 1'b1;
                    rx_ovf   <= ovf || beat_over;
                    beat_ptr <= '0;
                    byte_cnt <= '0;
                    ovf      <= 1'b0;
                end else if (beat_over) begin
                    // past MTU, drop beats until tlast
                    ovf <= 1'b1;
                end else begin
                    beat_ptr <= beat_ptr + 1'b1;
                    byte_cnt <= byte_cnt
                              + pkt_chk_pkg::BLEN_W'(pkt_chk_pkg::DATA_BYTES);
                end
            end
        end
    end

    // packet payload
    always_ff @(posedge clk) begin
        if (beat_acc && !beat_over) begin
            rx_pkt.data[beat_ptr[$clog2(pkt_chk_pkg::MTU_BEATS)-1:0]
                        * pkt_chk_pkg::DATA_BYTES*8 +: pkt_chk_pkg::DATA_BYTES*8]
                <= s_beat.tdata;
        end
        // full beats plus the partial last one
        if (beat_acc && s_beat.tlast) begin
            rx_pkt.blen <= byte_cnt + last_bytes;
        end
    end

    // only the last beat may be partial
    a_full_keep: assert property (@(posedge clk) disable iff (!rst_n)
        beat_acc && !s_beat.tlast |-> s_beat.tkeep == '1);

    // last beat keeps a run of bytes from byte 0
    a_last_keep: assert property (@(posedge clk) disable iff (!rst_n)
        beat_acc && s_beat.tlast |->
            (s_beat.tkeep != '0) && ((s_beat.tkeep & (s_beat.tkeep + 1'b1)) == '0));

    // source holds a stalled beat
    a_src_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_valid && !s_ready |=> s_valid && $stable(s_beat));

endmodule

// File: design/pkt_chk_pkg.sv
// packet checker shared types
// sizes, stream and packet structs, matcher states

package pkt_chk_pkg;

    // number of checked stream ports
    localparam int NUM_PORTS = 4;

    // bytes carried per stream beat
    localparam int DATA_BYTES = 4;

    // largest packet in bytes and in beats
    localparam int MTU_BYTES = 32;
    localparam int MTU_BEATS = MTU_BYTES / DATA_BYTES;

    // byte length holds 0 up to MTU_BYTES inclusive
    localparam int BLEN_W = $clog2(MTU_BYTES + 1);

    // expected packet slots per port
    localparam int MAX_PKTS = 4;
    localparam int SLOT_W = $clog2(MAX_PKTS);

    // match and miss counters
    localparam int CNT_W = 8;

    // one stream beat
    // byte 0 of the beat sits in tdata[7:0]
    typedef struct packed {
        logic [DATA_BYTES*8-1:0] tdata;
        logic [DATA_BYTES-1:0]   tkeep;
        logic                    tlast;
    } axis_beat_t;

    // one whole packet, received or expected
    // byte 0 in the low bits, bytes at and above blen are don't care
    typedef struct packed {
        logic [MTU_BYTES*8-1:0] data;
        logic [BLEN_W-1:0]      blen;
    } pkt_t;

    // per-packet result strobes
    // match and miss are one-cycle pulses, slot valid with match
    typedef struct packed {
        logic              match;
        logic              miss;
        logic [SLOT_W-1:0] slot;
    } chk_result_t;

    // matcher FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SCAN,
        ST_REPORT
    } match_state_e;

endpackage

// File: design/pkt_matcher.sv
// expected packet table and matcher
// one slot per cycle, counts and done level

`timescale 1ns/1ps

module pkt_matcher (
    input  logic                             clk,
    input  logic                             rst_n,
    // table load
    input  logic                             exp_wr,
    input  logic [pkt_chk_pkg::SLOT_W-1:0]   exp_slot,
    input  pkt_chk_pkg::pkt_t                exp_pkt,
    // received packet
    input  logic                             rx_valid,
    input  pkt_chk_pkg::pkt_t                rx_pkt,
    input  logic                             rx_ovf,
    output logic                             busy,
    // results
    output pkt_chk_pkg::chk_result_t         result,
    output logic [pkt_chk_pkg::CNT_W-1:0]    match_cnt,
    output logic [pkt_chk_pkg::CNT_W-1:0]    miss_cnt,
    output logic                             done
);

    // expected packets
    pkt_chk_pkg::pkt_t                   exp_tbl [pkt_chk_pkg::MAX_PKTS];
    logic [pkt_chk_pkg::MAX_PKTS-1:0]    loaded;
    logic [pkt_chk_pkg::MAX_PKTS-1:0]    rcvd;

    pkt_chk_pkg::match_state_e           state;
    // slot under compare and later the reported slot
    logic [pkt_chk_pkg::SLOT_W-1:0]      slot_idx;
    // latched packet under test
    pkt_chk_pkg::pkt_t                   rx_q;
    logic                                ovf_q;
    logic                                hit_q;
    logic                                slot_eq;
    logic                                slot_hit;

    assign busy = (state != pkt_chk_pkg::ST_IDLE);

    // done once every loaded slot has been seen
    assign done = (|loaded) && ((loaded & ~rcvd) == '0);

    // table writes
    always_ff @(posedge clk) begin
        if (exp_wr) begin
            exp_tbl[exp_slot] <= exp_pkt;
        end
    end

    // snapshot of the packet under compare
    always_ff @(posedge clk) begin
        if (rx_valid && (state == pkt_chk_pkg::ST_IDLE)) begin
            rx_q <= rx_pkt;
        end
    end

    // length equal and every byte below blen equal
    always_comb begin
        slot_eq = (exp_tbl[slot_idx].blen == rx_q.blen);
        for (int b = 0; b < pkt_chk_pkg::MTU_BYTES; b++) begin
            if ((b < rx_q.blen)
                && (exp_tbl[slot_idx].data[b*8 +: 8] != rx_q.data[b*8 +: 8])) begin
                slot_eq = 1'b0;
            end
        end
        // a received slot matches again only after a reload
        slot_hit = loaded[slot_idx] && !rcvd[slot_idx] && slot_eq;
    end

    // strobes only in the report cycle
    always_comb begin
        result.match = (state == pkt_chk_pkg::ST_REPORT) && hit_q;
        result.miss  = (state == pkt_chk_pkg::ST_REPORT) && !hit_q;
        result.slot  = slot_idx;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= pkt_chk_pkg::ST_IDLE;
            slot_idx  <= '0;
            ovf_q     <= 1'b0;
            hit_q     <= 1'b0;
            loaded    <= '0;
            rcvd      <= '0;
            match_cnt <= '0;
            miss_cnt  <= '0;
        end else begin
            case (state)
                pkt_chk_pkg::ST_IDLE: begin
                    if (rx_valid) begin
                        slot_idx <= '0;
                        ovf_q    <= rx_ovf;
                        state    <= pkt_chk_pkg::ST_SCAN;
                    end
                end
                pkt_chk_pkg::ST_SCAN: begin
                    if (ovf_q) begin
                        // oversize packet skips the table
                        hit_q    <= 1'b0;
                        miss_cnt <= miss_cnt + 1'b1;
                        state    <= pkt_chk_pkg::ST_REPORT;
                    end else if (slot_hit) begin
                        hit_q          <= 1'b1;
                        rcvd[slot_idx] <= 1'b1;
                        match_cnt      <= match_cnt + 1'b1;
                        state          <= pkt_chk_pkg::ST_REPORT;
                    end else if (slot_idx == pkt_chk_pkg::SLOT_W'(pkt_chk_pkg::MAX_PKTS - 1)) begin
                        // ran off the table
                        hit_q    <= 1'b0;
                        miss_cnt <= miss_cnt + 1'b1;
                        state    <= pkt_chk_pkg::ST_REPORT;
                    end else begin
                        slot_idx <= slot_idx + 1'b1;
                    end
                end
                pkt_chk_pkg::ST_REPORT: begin
                    state <= pkt_chk_pkg::ST_IDLE;
                end
                default: begin
                    state <= pkt_chk_pkg::ST_IDLE;
                end
            endcase

            // a load rearms the slot and wins over a same-cycle match
            if (exp_wr) begin
                loaded[exp_slot] <= 1'b1;
                rcvd[exp_slot]   <= 1'b0;
            end
        end
    end

    // each count moves in its own strobe cycle and in no other
    a_cnt_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        (result.match == (match_cnt != $past(match_cnt)))
        && (result.miss == (miss_cnt != $past(miss_cnt))));

    // assembler must wait out a compare
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |-> !busy);

endmodule

// File: include/tb_pkt_chk_tasks.svh
// directed tests and stimulus helpers
// included inside the testbench module

`ifndef TB_PKT_CHK_TASKS_SVH
`define TB_PKT_CHK_TASKS_SVH

// cut a packet into beats with nbytes possibly past the MTU
task automatic send_packet(input int p, input pkt_chk_pkg::pkt_t pk, input int nbytes);
    pkt_chk_pkg::axis_beat_t beat;
    int nbeats;
    int idx;
    nbeats = (nbytes + pkt_chk_pkg::DATA_BYTES - 1) / pkt_chk_pkg::DATA_BYTES;
    for (int i = 0; i < nbeats; i++) begin
        beat = '0;
        for (int k = 0; k < pkt_chk_pkg::DATA_BYTES; k++) begin
            idx = i * pkt_chk_pkg::DATA_BYTES + k;
            if (idx < pkt_chk_pkg::MTU_BYTES) begin
                beat.tdata[k*8 +: 8] = pk.data[idx*8 +: 8];
            end else begin
                // filler past the MTU
                beat.tdata[k*8 +: 8] = 8'(idx);
            end
            beat.tkeep[k] = (idx < nbytes);
        end
        beat.tlast = (i == nbeats - 1);
        s_beat[p]  = beat;
        s_valid[p] = 1'b1;
        // held stable until the port takes it
        while (!s_ready[p]) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    end
    s_valid[p] = 1'b0;
endtask

task automatic load_slot(input int p, input int slot, input pkt_chk_pkg::pkt_t pk);
    exp_wr   = 1'b1;
    exp_port = p[$clog2(pkt_chk_pkg::NUM_PORTS)-1:0];
    exp_slot = slot[pkt_chk_pkg::SLOT_W-1:0];
    exp_pkt  = pk;
    @(posedge clk);
    #1;
    exp_wr = 1'b0;
endtask

task automatic port_traffic(input int p, input pkt_chk_pkg::pkt_t pk);
    send_packet(p, pk, pk.blen);
    wait_result(p, 1'b1, p);
endtask

task automatic reset_values();
    for (int p = 0; p < pkt_chk_pkg::NUM_PORTS; p++) begin
        check_val("ready", p, s_ready[p], 1);
        check_val("match_cnt", p, match_cnt[p], 0);
        check_val("miss_cnt", p, miss_cnt[p], 0);
        check_val("done", p, done[p], 0);
        check_val("strobe", p, result[p].match || result[p].miss, 0);
    end
endtask

// 13 bytes with one byte kept in the last beat
task automatic partial_beat_match();
    pkt_chk_pkg::pkt_t pk;
    rand_pkt(pk, 13);
    load_slot(0, 2, pk);
    send_packet(0, pk, 13);
    wait_result(0, 1'b1, 2);
    check_val("done", 0, done[0], 1);
endtask

task automatic corrupt_and_long();
    pkt_chk_pkg::pkt_t pk;
    pkt_chk_pkg::pkt_t bad;
    pkt_chk_pkg::pkt_t longer;
    rand_pkt(pk, 13);
    // reload arms slot 2 again
    load_slot(0, 2, pk);
    check_val("done after reload", 0, done[0], 0);
    bad = pk;
    bad.data[5*8 +: 8] = pk.data[5*8 +: 8] ^ 8'h40;
    send_packet(0, bad, 13);
    wait_result(0, 1'b0, 0);
    longer = pk;
    longer.data[13*8 +: 8] = 8'h5a;
    longer.blen = pkt_chk_pkg::BLEN_W'(14);
    send_packet(0, longer, 14);
    wait_result(0, 1'b0, 0);
    check_val("done after misses", 0, done[0], 0);
    // the intact packet still finds its slot
    send_packet(0, pk, 13);
    wait_result(0, 1'b1, 2);
endtask

task automatic out_of_order_slots();
    pkt_chk_pkg::pkt_t pk [3];
    rand_pkt(pk[0], 8);
    rand_pkt(pk[1], 20);
    rand_pkt(pk[2], 32);
    load_slot(1, 0, pk[0]);
    load_slot(1, 1, pk[1]);
    load_slot(1, 3, pk[2]);
    send_packet(1, pk[2], 32);
    wait_result(1, 1'b1, 3);
    check_val("done", 1, done[1], 0);
    send_packet(1, pk[0], 8);
    wait_result(1, 1'b1, 0);
    check_val("done", 1, done[1], 0);
    send_packet(1, pk[1], 20);
    wait_result(1, 1'b1, 1);
    check_val("done", 1, done[1], 1);
    // slot 3 already taken
    send_packet(1, pk[2], 32);
    wait_result(1, 1'b0, 0);
    check_val("done after repeat", 1, done[1], 1);
endtask

// ten beats with two past the MTU
task automatic oversize_packet();
    pkt_chk_pkg::pkt_t pk;
    rand_pkt(pk, pkt_chk_pkg::MTU_BYTES);
    send_packet(2, pk, pkt_chk_pkg::MTU_BYTES + 6);
    // no table scan, so the miss shows two cycles after rx_valid
    repeat (2) begin
        @(posedge clk);
        #1;
    end
    check_val("oversize miss", 2, result[2].miss, 1);
    wait_result(2, 1'b0, 0);
    check_val("done", 2, done[2], 0);
endtask

task automatic parallel_ports();
    pkt_chk_pkg::pkt_t pk [pkt_chk_pkg::NUM_PORTS];
    for (int p = 0; p < pkt_chk_pkg::NUM_PORTS; p++) begin
        rand_pkt(pk[p], 9 + 5 * p);
        load_slot(p, p, pk[p]);
    end
    for (int p = 0; p < pkt_chk_pkg::NUM_PORTS; p++) begin
        automatic int q = p;
        fork
            port_traffic(q, pk[q]);
        join_none
    end
    wait fork;
    // each port counts only its own traffic
    for (int p = 0; p < pkt_chk_pkg::NUM_PORTS; p++) begin
        check_val("final match_cnt", p, match_cnt[p], exp_match[p]);
        check_val("final miss_cnt", p, miss_cnt[p], exp_miss[p]);
        // every loaded slot on every port has now been received
        check_val("final done", p, done[p], 1);
    end
endtask

`endif

// File: dv/tb_axis_array_pkt_chk.sv
// packet checker array testbench
// directed tests over all ports

`timescale 1ns/1ps

module tb_axis_array_pkt_chk;

    localparam int RESET_CYCLES = 5;
    // cycles to wait for a result strobe after the last beat
    localparam int RESULT_WAIT = pkt_chk_pkg::MAX_PKTS + 2;
    // worst single packet with oversize beats, full scan and handshake slack
    localparam int PKT_CYCLES = pkt_chk_pkg::MTU_BEATS + pkt_chk_pkg::MAX_PKTS + 8;
    localparam int NUM_SENDS = 13;
    localparam int NUM_LOADS = 9;
    localparam int WATCHDOG_CYCLES =
        2 * (RESET_CYCLES + NUM_SENDS * PKT_CYCLES + NUM_LOADS * 2);

    logic                                                         clk;
    logic                                                         rst_n;
    logic [pkt_chk_pkg::NUM_PORTS-1:0]                            s_valid;
    pkt_chk_pkg::axis_beat_t [pkt_chk_pkg::NUM_PORTS-1:0]         s_beat;
    logic [pkt_chk_pkg::NUM_PORTS-1:0]                            s_ready;
    logic                                                         exp_wr;
    logic [$clog2(pkt_chk_pkg::NUM_PORTS)-1:0]                    exp_port;
    logic [pkt_chk_pkg::SLOT_W-1:0]                               exp_slot;
    pkt_chk_pkg::pkt_t                                            exp_pkt;
    pkt_chk_pkg::chk_result_t [pkt_chk_pkg::NUM_PORTS-1:0]        result;
    logic [pkt_chk_pkg::NUM_PORTS-1:0][pkt_chk_pkg::CNT_W-1:0]    match_cnt;
    logic [pkt_chk_pkg::NUM_PORTS-1:0][pkt_chk_pkg::CNT_W-1:0]    miss_cnt;
    logic [pkt_chk_pkg::NUM_PORTS-1:0]                            done;

    // packet byte source
    logic [15:0] lfsr_state;
    int          n_checks;
    int          n_errors;
    // counts each port should show
    int          exp_match [pkt_chk_pkg::NUM_PORTS];
    int          exp_miss [pkt_chk_pkg::NUM_PORTS];

    axis_array_pkt_chk u_axis_array_pkt_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_valid   (s_valid),
        .s_beat    (s_beat),
        .s_ready   (s_ready),
        .exp_wr    (exp_wr),
        .exp_port  (exp_port),
        .exp_slot  (exp_slot),
        .exp_pkt   (exp_pkt),
        .result    (result),
        .match_cnt (match_cnt),
        .miss_cnt  (miss_cnt),
        .done      (done)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run length limit
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, %0d checks, %0d errors",
                 WATCHDOG_CYCLES, n_checks, n_errors);
        $display("RESULT: FAIL");
        $finish;
    end

    // right shift Fibonacci form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
    endfunction

    // one lfsr step per data bit
    task automatic rand_pkt(output pkt_chk_pkg::pkt_t pk, input int len);
        logic [7:0] byte_v;
        pk      = '0;
        pk.blen = pkt_chk_pkg::BLEN_W'(len);
        for (int i = 0; i < len; i++) begin
            for (int j = 0; j < 8; j++) begin
                byte_v[j]  = lfsr_state[0];
                lfsr_state = lfsr_next(lfsr_state);
            end
            pk.data[i*8 +: 8] = byte_v;
        end
    endtask

    task automatic check_val(input string what, input int p, input int got, input int want);
        n_checks++;
        if (got != want) begin
            n_errors++;
            $display("Fail %0t: port %0d %s is %0d, expected %0d", $time, p, what, got, want);
        end
    endtask

    // wait for the strobe and check it with the counts and tready
    task automatic wait_result(input int p, input bit want_match, input int want_slot);
        int waited;
        waited = 0;
        while (!(result[p].match || result[p].miss) && waited < RESULT_WAIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!(result[p].match || result[p].miss)) begin
            n_errors++;
            $display("port %0d gave no result strobe within %0d cycles", p, RESULT_WAIT);
        end else begin
            if (want_match) begin
                exp_match[p]++;
            end else begin
                exp_miss[p]++;
            end
            check_val("match strobe", p, result[p].match, want_match);
            check_val("miss strobe", p, result[p].miss, !want_match);
            if (want_match) begin
                check_val("slot", p, result[p].slot, want_slot);
            end
            check_val("match_cnt", p, match_cnt[p], exp_match[p]);
            check_val("miss_cnt", p, miss_cnt[p], exp_miss[p]);
            // still stalled in the report cycle
            check_val("ready at result", p, s_ready[p], 0);
            @(posedge clk);
            #1;
            check_val("strobe after result", p, result[p].match || result[p].miss, 0);
            check_val("ready after result", p, s_ready[p], 1);
        end
    endtask

    `include "tb_pkt_chk_tasks.svh"

    initial begin
        lfsr_state = 16'd7;
        n_checks   = 0;
        n_errors   = 0;
        rst_n      = 1'b0;
        s_valid    = '0;
        s_beat     = '0;
        exp_wr     = 1'b0;
        exp_port   = '0;
        exp_slot   = '0;
        exp_pkt    = '0;
        for (int p = 0; p < pkt_chk_pkg::NUM_PORTS; p++) begin
            exp_match[p] = 0;
            exp_miss[p]  = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        reset_values();
        partial_beat_match();
        corrupt_and_long();
        out_of_order_slots();
        oversize_packet();
        parallel_ports();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
design/pkt_chk_pkg.sv
design/pkt_assembler.sv
design/pkt_matcher.sv
design/axis_pkt_chk.sv
design/axis_array_pkt_chk.sv
dv/tb_axis_array_pkt_chk.sv
